// ==== hw/core_types_pkg.sv ====
`default_nettype none

package core_types_pkg;

    // Basic datapath widths
    typedef logic [31:0] data_word_t;       // Result word
    typedef logic [4:0]  reg_addr_t;        // Architectural register
    typedef logic [5:0]  rob_tag_t;         // Covers the whole ROB

    // Trap record, packs into exactly one word
    typedef struct packed {
        logic        interrupt;             // Async source
        logic [3:0]  cause;                 // Trap cause code
        logic [26:0] addr_offset;           // Faulting address offset
    } trap_info_t;

    // Same 32 bits, meaning picked by the exception flag
    typedef union packed {
        data_word_t data;                   // Flag clear
        trap_info_t trap;                   // Flag set
    } rob_payload_u;

    // Control half of a result, all zero when idle
    typedef struct packed {
        rob_tag_t  rob_tag;
        reg_addr_t reg_dest;
        logic      exception;
    } instr_packet_t;

    // What the buffers store and the arbiter moves
    typedef struct packed {
        instr_packet_t ipacket;
        rob_payload_u  payload;
    } commit_entry_t;

    // ROB slot contents, the tag is the slot index
    typedef struct packed {
        reg_addr_t    reg_dest;
        logic         exception;
        rob_payload_u payload;
    } rob_entry_t;

    // Producer channels
    // ITU and LSU double as buffer indices
    localparam int ITU = 0;
    localparam int LSU = 1;
    localparam int CSR = 2;

endpackage : core_types_pkg

`default_nettype wire

// ==== hw/commit_cfg_pkg.sv ====
`default_nettype none

package commit_cfg_pkg;

    // Commit buffer geometry, depth kept a power of two
    localparam int COMMIT_BUF_DEPTH = 4;
    localparam int BUF_PTR_W        = $clog2(COMMIT_BUF_DEPTH);
    localparam int BUF_CNT_W        = BUF_PTR_W + 1;   // Counts up to full

    // One slot per tag value
    localparam int ROB_DEPTH = 64;

    // Source operands looked up per cycle
    localparam int FWD_PORTS = 2;

endpackage : commit_cfg_pkg

`default_nettype wire

// ==== hw/commit_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_buffer
    import core_types_pkg::*;
    import commit_cfg_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          flush_i,

    // FIFO control
    input  wire logic                          push_i,
    input  wire logic                          pop_i,
    input  wire commit_entry_t                 entry_i,

    // Newer value for a register arrived on the other channel
    input  wire logic                          invalidate_i,
    input  wire reg_addr_t                     invalid_reg_i,

    // Operand forwarding
    input  wire reg_addr_t [FWD_PORTS-1:0]     fwd_src_i,
    output data_word_t     [FWD_PORTS-1:0]     fwd_data_o,
    output logic           [FWD_PORTS-1:0]     fwd_valid_o,

    // Status
    output commit_entry_t                      head_o,
    output logic                               full_o,
    output logic                               empty_o
);

    commit_entry_t               buf_q [COMMIT_BUF_DEPTH];
    logic [COMMIT_BUF_DEPTH-1:0] fwd_ok_q;      // Slot still holds youngest value
    logic [BUF_PTR_W-1:0]        wr_ptr_q;
    logic [BUF_PTR_W-1:0]        rd_ptr_q;
    logic [BUF_CNT_W-1:0]        count_q;

    assign full_o  = (count_q == BUF_CNT_W'(COMMIT_BUF_DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = buf_q[rd_ptr_q];           // First-word fall-through

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            buf_q[wr_ptr_q] <= entry_i;
        end
    end

    // Pointers, occupancy and forward flags
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            fwd_ok_q <= '0;
        end else begin
            // Stale copies lose their forward right
            if (invalidate_i) begin
                for (int i = 0; i < COMMIT_BUF_DEPTH; i++) begin
                    if (buf_q[i].ipacket.reg_dest == invalid_reg_i) begin
                        fwd_ok_q[i] <= 1'b0;
                    end
                end
            end

            if (push_i) begin
                fwd_ok_q[wr_ptr_q] <= 1'b1;     // Wins over invalidate above
                wr_ptr_q           <= wr_ptr_q + 1'b1;
            end

            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Idle or both
            endcase
        end
    end

    // Forward lookup, walk oldest to youngest so the last hit wins
    always_comb begin
        logic [BUF_PTR_W-1:0] idx;

        idx = rd_ptr_q;
        for (int p = 0; p < FWD_PORTS; p++) begin
            fwd_data_o[p]  = '0;
            fwd_valid_o[p] = 1'b0;
            for (int k = 0; k < COMMIT_BUF_DEPTH; k++) begin
                idx = rd_ptr_q + BUF_PTR_W'(k);    // Wraps with the pointer
                if ((BUF_CNT_W'(k) < count_q) && fwd_ok_q[idx] &&
                    (buf_q[idx].ipacket.reg_dest == fwd_src_i[p])) begin
                    fwd_data_o[p]  = buf_q[idx].payload.data;
                    fwd_valid_o[p] = 1'b1;
                end
            end
        end
    end

endmodule : commit_buffer

`default_nettype wire

// ==== hw/commit_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_arbiter
    import core_types_pkg::*;
(
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                flush_i,

    // Buffer side, indexed by ITU and LSU
    input  wire logic          [1:0] empty_i,
    input  wire commit_entry_t [1:0] head_i,
    input  wire commit_entry_t [1:0] incoming_i,
    input  wire logic          [1:0] incoming_valid_i,
    output logic               [1:0] push_o,
    output logic               [1:0] pop_o,

    // Single ROB write port
    output logic                     rob_write_o,
    output rob_tag_t                 rob_tag_o,
    output rob_entry_t               rob_entry_o
);

    typedef enum logic {
        TURN_ITU,
        TURN_LSU
    } turn_t;

    turn_t         turn_q, turn_d;
    logic          gnt;                 // Channel holding the port
    logic          oth;                 // Channel waiting
    commit_entry_t sel_entry;

    // Tag becomes the slot address, the rest is stored
    function automatic rob_entry_t to_rob_entry(input commit_entry_t ce);
        rob_entry_t re;

        re.reg_dest  = ce.ipacket.reg_dest;
        re.exception = ce.ipacket.exception;
        re.payload   = ce.payload;
        return re;
    endfunction

    assign gnt = (turn_q == TURN_LSU) ? 1'(LSU) : 1'(ITU);
    assign oth = ~gnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            turn_q <= TURN_ITU;
        end else begin
            turn_q <= turn_d;
        end
    end

    always_comb begin
        turn_d      = turn_q;
        push_o      = '0;
        pop_o       = '0;
        rob_write_o = 1'b0;
        sel_entry   = '0;

        if (!empty_i[gnt]) begin
            // Drain oldest, fresh result queues behind it
            pop_o[gnt]  = 1'b1;
            push_o[gnt] = incoming_valid_i[gnt];
            sel_entry   = head_i[gnt];
            rob_write_o = 1'b1;
        end else if (incoming_valid_i[gnt]) begin
            sel_entry   = incoming_i[gnt];  // Bypass, nothing older waiting
            rob_write_o = 1'b1;
        end

        // Waiting channel always queues
        push_o[oth] = incoming_valid_i[oth];

        // Hand over only when there is something to drain
        if (!empty_i[oth]) begin
            turn_d = (oth == 1'(LSU)) ? TURN_LSU : TURN_ITU;
        end
    end

    assign rob_tag_o   = sel_entry.ipacket.rob_tag;
    assign rob_entry_o = to_rob_entry(sel_entry);

endmodule : commit_arbiter

`default_nettype wire

// ==== hw/commit_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_stage
    import core_types_pkg::*;
    import commit_cfg_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          flush_i,

    // Producers, indexed by ITU, LSU, CSR
    input  wire commit_entry_t [2:0]           result_i,
    input  wire logic          [2:0]           result_valid_i,
    output logic                               stall_o,

    // ROB write port
    output logic                               rob_write_o,
    output rob_tag_t                           rob_tag_o,
    output rob_entry_t                         rob_entry_o,

    // Operand forwarding
    input  wire reg_addr_t     [FWD_PORTS-1:0] fwd_src_i,
    output data_word_t         [FWD_PORTS-1:0] fwd_data_o,
    output logic               [FWD_PORTS-1:0] fwd_valid_o
);

    commit_entry_t [1:0]                    chan_entry;
    logic          [1:0]                    chan_valid;
    commit_entry_t [1:0]                    buf_head;
    logic          [1:0]                    buf_push, buf_pop;
    logic          [1:0]                    buf_full, buf_empty;
    data_word_t    [1:0][FWD_PORTS-1:0]     buf_fwd_data;
    logic          [1:0][FWD_PORTS-1:0]     buf_fwd_valid;

    // ITU and CSR never finish together, idle packets are zero
    assign chan_entry[ITU] = result_i[ITU] | result_i[CSR];
    assign chan_valid[ITU] = result_valid_i[ITU] | result_valid_i[CSR];
    assign chan_entry[LSU] = result_i[LSU];
    assign chan_valid[LSU] = result_valid_i[LSU];

    for (genvar ch = 0; ch < 2; ch++) begin : g_buf
        // Any arrival on the other side is younger, pushed or bypassed
        commit_buffer u_buf (
            .clk_i         ( clk_i                                 ),
            .rst_n_i       ( rst_n_i                               ),
            .flush_i       ( flush_i                               ),
            .push_i        ( buf_push[ch]                          ),
            .pop_i         ( buf_pop[ch]                           ),
            .entry_i       ( chan_entry[ch]                        ),
            .invalidate_i  ( chan_valid[1-ch]                      ),
            .invalid_reg_i ( chan_entry[1-ch].ipacket.reg_dest     ),
            .fwd_src_i     ( fwd_src_i                             ),
            .fwd_data_o    ( buf_fwd_data[ch]                      ),
            .fwd_valid_o   ( buf_fwd_valid[ch]                     ),
            .head_o        ( buf_head[ch]                          ),
            .full_o        ( buf_full[ch]                          ),
            .empty_o       ( buf_empty[ch]                         )
        );
    end

    commit_arbiter u_arbiter (
        .clk_i            ( clk_i       ),
        .rst_n_i          ( rst_n_i     ),
        .flush_i          ( flush_i     ),
        .empty_i          ( buf_empty   ),
        .head_i           ( buf_head    ),
        .incoming_i       ( chan_entry  ),
        .incoming_valid_i ( chan_valid  ),
        .push_o           ( buf_push    ),
        .pop_o            ( buf_pop     ),
        .rob_write_o      ( rob_write_o ),
        .rob_tag_o        ( rob_tag_o   ),
        .rob_entry_o      ( rob_entry_o )
    );

    assign stall_o = |buf_full;

    always_comb begin
        for (int p = 0; p < FWD_PORTS; p++) begin
            fwd_data_o[p]  = '0;
            fwd_valid_o[p] = 1'b0;

            // Invalidation leaves at most one buffer with a live hit
            if (buf_fwd_valid[ITU][p]) begin
                fwd_data_o[p]  = buf_fwd_data[ITU][p];
                fwd_valid_o[p] = 1'b1;
            end else if (buf_fwd_valid[LSU][p]) begin
                fwd_data_o[p]  = buf_fwd_data[LSU][p];
                fwd_valid_o[p] = 1'b1;
            end

            // Arrivals this cycle are newest
            for (int ch = 0; ch < 2; ch++) begin
                if (chan_valid[ch] && (chan_entry[ch].ipacket.reg_dest == fwd_src_i[p])) begin
                    fwd_data_o[p]  = chan_entry[ch].payload.data;
                    fwd_valid_o[p] = 1'b1;
                end
            end
        end
    end

endmodule : commit_stage

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer
    import core_types_pkg::*;
    import commit_cfg_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       flush_i,

    // Write port from the commit stage
    input  wire logic       write_i,
    input  wire rob_tag_t   tag_i,
    input  wire rob_entry_t entry_i,

    // In-order retire
    output logic            retire_valid_o,
    output rob_tag_t        retire_tag_o,
    output rob_entry_t      retire_entry_o
);

    rob_entry_t             slot_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   valid_q;
    rob_tag_t               head_q;         // Oldest tag in flight

    // Head retires as soon as its result lands
    assign retire_valid_o = valid_q[head_q];
    assign retire_tag_o   = head_q;
    assign retire_entry_o = slot_q[head_q];

    // Entry storage, addressed by tag
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            slot_q[tag_i] <= entry_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
            head_q  <= '0;
        end else begin
            if (write_i) begin
                valid_q[tag_i] <= 1'b1;
            end

            // Free the slot and step to the next tag
            if (retire_valid_o) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;   // Wraps with tag space
            end
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// ==== hw/commit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_top
    import core_types_pkg::*;
    import commit_cfg_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          flush_i,

    // Producers
    input  wire commit_entry_t [2:0]           result_i,
    input  wire logic          [2:0]           result_valid_i,
    output logic                               stall_o,

    // Forwarding
    input  wire reg_addr_t     [FWD_PORTS-1:0] fwd_src_i,
    output data_word_t         [FWD_PORTS-1:0] fwd_data_o,
    output logic               [FWD_PORTS-1:0] fwd_valid_o,

    // Retire
    output logic                               retire_valid_o,
    output rob_tag_t                           retire_tag_o,
    output rob_entry_t                         retire_entry_o
);

    logic       rob_write;
    rob_tag_t   rob_tag;
    rob_entry_t rob_entry;

    commit_stage u_commit_stage (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .flush_i        ( flush_i        ),
        .result_i       ( result_i       ),
        .result_valid_i ( result_valid_i ),
        .stall_o        ( stall_o        ),
        .rob_write_o    ( rob_write      ),
        .rob_tag_o      ( rob_tag        ),
        .rob_entry_o    ( rob_entry      ),
        .fwd_src_i      ( fwd_src_i      ),
        .fwd_data_o     ( fwd_data_o     ),
        .fwd_valid_o    ( fwd_valid_o    )
    );

    reorder_buffer u_rob (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .flush_i        ( flush_i        ),
        .write_i        ( rob_write      ),
        .tag_i          ( rob_tag        ),
        .entry_i        ( rob_entry      ),
        .retire_valid_o ( retire_valid_o ),
        .retire_tag_o   ( retire_tag_o   ),
        .retire_entry_o ( retire_entry_o )
    );

endmodule : commit_top

`default_nettype wire

// ==== tests/commit_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_props
    import core_types_pkg::*;
(
    input wire logic       clk_i,
    input wire logic       rst_n_i,
    input wire logic       flush_i,
    input wire logic [2:0] result_valid_i,
    input wire logic [1:0] push_i,      // Per buffer, ITU and LSU
    input wire logic [1:0] pop_i,
    input wire logic [1:0] full_i,
    input wire logic [1:0] empty_i
);

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
            !(push_i[ch] && full_i[ch]))
            else $error("Commit buffer %0d pushed while full", ch);

        a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
            !(pop_i[ch] && empty_i[ch]))
            else $error("Commit buffer %0d popped while empty", ch);
    end

    // Shared channel relies on this
    a_itu_csr_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({result_valid_i[ITU], result_valid_i[CSR]}))
        else $error("ITU and CSR valid in the same cycle");

endmodule : commit_props

bind commit_stage commit_props u_props (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .flush_i        ( flush_i        ),
    .result_valid_i ( result_valid_i ),
    .push_i         ( buf_push       ),
    .pop_i          ( buf_pop        ),
    .full_i         ( buf_full       ),
    .empty_i        ( buf_empty      )
);

`default_nettype wire

// ==== tests/commit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_tb
    import core_types_pkg::*;
    import commit_cfg_pkg::*;
();

    logic                       clk_i = 1'b0;
    logic                       rst_n_i;
    logic                       flush_i;
    commit_entry_t [2:0]        drv_entry;      // Idle channels stay all zero
    logic          [2:0]        drv_want;       // Producer has a result ready
    logic          [2:0]        result_valid;
    reg_addr_t     [FWD_PORTS-1:0] fwd_src;
    data_word_t    [FWD_PORTS-1:0] fwd_data;
    logic          [FWD_PORTS-1:0] fwd_valid;
    logic                       stall;
    logic                       retire_valid;
    rob_tag_t                   retire_tag;
    rob_entry_t                 retire_entry;

    int       errors, checks, sent_cnt, retired_cnt, total_retired, traps_seen;
    rob_tag_t next_tag, exp_tag;                // Dispatch side and retire side
    bit       stall_seen;
    rob_tag_t ic_tags[$];                       // Merged ITU/CSR stream in order
    int       ic_chan[$];                       // ITU or CSR per tag
    rob_tag_t lsu_tags[$];

    // Producers hold their result back while the stage is stalled
    assign result_valid = drv_want & {3{~stall}};

    always #20 clk_i = ~clk_i;

    commit_top commit_top_i (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .flush_i        ( flush_i      ),
        .result_i       ( drv_entry    ),
        .result_valid_i ( result_valid ),
        .stall_o        ( stall        ),
        .fwd_src_i      ( fwd_src      ),
        .fwd_data_o     ( fwd_data     ),
        .fwd_valid_o    ( fwd_valid    ),
        .retire_valid_o ( retire_valid ),
        .retire_tag_o   ( retire_tag   ),
        .retire_entry_o ( retire_entry )
    );

    // What the ROB must hold for a tag
    function automatic rob_entry_t expected_entry(input rob_tag_t tag);
        rob_entry_t e;
        int         t;

        t           = int'(tag);
        e.reg_dest  = reg_addr_t'(t * 11 + 5);
        e.exception = (t % 7 == 0);
        if (e.exception) begin
            e.payload.trap.interrupt   = tag[5];
            e.payload.trap.cause       = tag[3:0];    // Cause follows the low tag bits
            e.payload.trap.addr_offset = {tag, 21'h0a5c3};
        end else begin
            e.payload.data = 32'(t) * 32'h0100_0193 ^ 32'h5a5a_0000;
        end
        return e;
    endfunction

    function automatic commit_entry_t make_entry(input rob_tag_t tag);
        rob_entry_t    e;
        commit_entry_t c;

        e                   = expected_entry(tag);
        c.ipacket.rob_tag   = tag;
        c.ipacket.reg_dest  = e.reg_dest;
        c.ipacket.exception = e.exception;
        c.payload           = e.payload;
        return c;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, act_v);
        errors++;
    endtask

    // At most one retire per cycle
    always @(negedge clk_i) begin
        rob_entry_t exp_e;

        if (!rst_n_i || flush_i) begin
            exp_tag     = '0;                   // Flushed retire is cancelled
            retired_cnt = 0;
        end else if (retire_valid) begin
            exp_e = expected_entry(exp_tag);
            checks++;
            if (retired_cnt >= sent_cnt) begin
                $display("** Error at %0t: tag %0d retired but nothing was outstanding",
                         $time, retire_tag);
                errors++;
            end
            if (retire_tag != exp_tag)
                report_mismatch("retire_tag_o", 64'(exp_tag), 64'(retire_tag));
            if (retire_entry != exp_e)
                report_mismatch("retire_entry_o", 64'(exp_e), 64'(retire_entry));
            if (exp_e.exception) begin
                traps_seen++;
                if (retire_entry.payload.trap.cause != exp_tag[3:0])
                    report_mismatch("retire_entry_o.payload.trap.cause",
                                    64'(exp_tag[3:0]), 64'(retire_entry.payload.trap.cause));
            end
            exp_tag++;
            retired_cnt++;
            total_retired++;
        end
    end

    task automatic check_forward(input int port, input commit_entry_t ce);
        checks++;
        if (!fwd_valid[port]) begin
            $display("** Error at %0t: fwd_valid_o[%0d] expected 1, got 0", $time, port);
            errors++;
        end else if (fwd_data[port] != ce.payload.data) begin
            report_mismatch($sformatf("fwd_data_o[%0d]", port), 64'(ce.payload.data),
                            64'(fwd_data[port]));
        end
    endtask

    // Mode 0 is ITU only, 1 is CSR only, 2 splits randomly and 3 alternates
    task automatic queue_tags(input int n, input int mode);
        bit to_lsu;

        for (int i = 0; i < n; i++) begin
            to_lsu = (mode == 2) ? ($urandom_range(1) == 1) : (mode == 3 && i % 2 == 1);
            if (to_lsu) begin
                lsu_tags.push_back(next_tag);
            end else begin
                ic_tags.push_back(next_tag);
                if (mode < 2) ic_chan.push_back(mode == 1 ? CSR : ITU);
                else ic_chan.push_back($urandom_range(1) ? CSR : ITU);
            end
            next_tag++;
        end
    endtask

    task automatic shuffle_lsu();
        rob_tag_t tmp;
        int       j;

        for (int k = 0; k < lsu_tags.size(); k++) begin
            j           = $urandom_range(lsu_tags.size() - 1);
            tmp         = lsu_tags[k];
            lsu_tags[k] = lsu_tags[j];
            lsu_tags[j] = tmp;
        end
    endtask

    // Hand queued results to the DUT
    // gap_pct is the idle chance per channel
    task automatic run_streams(input int gap_pct);
        int            idle;
        bit            ic_on, lsu_on;
        logic [2:0]    want;
        commit_entry_t ic_e, lsu_e;

        idle = 0;
        while ((ic_tags.size() > 0 || lsu_tags.size() > 0) && idle < 200) begin
            ic_on  = (ic_tags.size() > 0) && ($urandom_range(99) >= gap_pct);
            lsu_on = (lsu_tags.size() > 0) && ($urandom_range(99) >= gap_pct);
            ic_e   = ic_on ? make_entry(ic_tags[0]) : '0;
            lsu_e  = lsu_on ? make_entry(lsu_tags[0]) : '0;
            want      = '0;
            want[ITU] = ic_on && (ic_chan[0] == ITU);
            want[CSR] = ic_on && (ic_chan[0] == CSR);
            want[LSU] = lsu_on;
            @(posedge clk_i);
            drv_want       <= want;
            drv_entry[ITU] <= want[ITU] ? ic_e : '0;
            drv_entry[CSR] <= want[CSR] ? ic_e : '0;
            drv_entry[LSU] <= lsu_e;
            fwd_src[0]     <= ic_e.ipacket.reg_dest;    // Look up what is arriving
            fwd_src[1]     <= lsu_e.ipacket.reg_dest;
            @(negedge clk_i);
            if (stall) begin
                stall_seen = 1'b1;
                idle++;
            end else begin
                // LSU arrival wins a shared register
                if (ic_on && !(lsu_on && lsu_e.ipacket.reg_dest == ic_e.ipacket.reg_dest))
                    check_forward(0, ic_e);
                if (lsu_on) check_forward(1, lsu_e);
                if (ic_on) begin
                    void'(ic_tags.pop_front());
                    void'(ic_chan.pop_front());
                    sent_cnt++;
                end
                if (lsu_on) begin
                    void'(lsu_tags.pop_front());
                    sent_cnt++;
                end
                idle = (ic_on || lsu_on) ? 0 : idle + 1;
            end
        end
        if (idle >= 200) begin
            $display("Timeout at %0t: producers could not hand over all results", $time);
            errors++;
            ic_tags.delete();
            ic_chan.delete();
            lsu_tags.delete();
        end
        @(posedge clk_i);
        drv_want  <= '0;
        drv_entry <= '0;
    endtask

    task automatic wait_drain();
        int n;

        n = 0;
        while (retired_cnt != sent_cnt && n < 500) begin
            @(posedge clk_i);
            n++;
        end
        if (retired_cnt != sent_cnt) begin
            $display("Timeout at %0t: only %0d of %0d results retired",
                     $time, retired_cnt, sent_cnt);
            errors++;
        end
    endtask

    // Nothing may forward once the buffers are drained
    task automatic check_idle_forward();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk_i);
            fwd_src[0] <= reg_addr_t'(r);
            fwd_src[1] <= reg_addr_t'(31 - r);
            @(negedge clk_i);
            checks++;
            if (fwd_valid != '0) report_mismatch("fwd_valid_o", 64'(0), 64'(fwd_valid));
        end
    endtask

    task automatic end_test(input string name, input int e0);
        if (errors == e0) $display("Test %s: pass", name);
        else $display("Test %s: FAIL with %0d errors", name, errors - e0);
    endtask

    initial begin
        int e0;
        int t0;

        void'($urandom(32'h21d533f2));
        rst_n_i   = 1'b0;
        flush_i   = 1'b0;
        drv_want  = '0;
        drv_entry = '0;
        fwd_src   = '0;
        next_tag  = '0;                         // First tag handed out after reset
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;

        e0 = errors;
        @(negedge clk_i);
        checks += 2;
        if (stall) report_mismatch("stall_o", 64'(0), 64'(stall));
        if (retire_valid) report_mismatch("retire_valid_o", 64'(0), 64'(retire_valid));
        check_idle_forward();
        end_test("1 reset state", e0);

        e0 = errors;
        t0 = traps_seen;
        queue_tags(20, 0);
        run_streams(30);
        wait_drain();
        queue_tags(20, 1);
        run_streams(30);
        wait_drain();
        checks++;
        if (traps_seen == t0) begin
            $display("No trap record retired on the ITU and CSR runs");
            errors++;
        end
        end_test("2 single channel in order", e0);

        e0 = errors;
        queue_tags(48, 2);
        shuffle_lsu();                          // LSU finishes out of order
        run_streams(40);
        wait_drain();
        end_test("3 out of order arrival", e0);

        e0 = errors;
        stall_seen = 1'b0;
        queue_tags(56, 3);
        run_streams(0);
        wait_drain();
        checks++;
        if (!stall_seen) begin
            $display("stall_o never rose during the burst");
            errors++;
        end
        end_test("4 burst with stall", e0);

        e0 = errors;
        queue_tags(24, 2);
        run_streams(20);
        wait_drain();
        check_idle_forward();
        end_test("5 operand forwarding", e0);

        e0 = errors;
        queue_tags(30, 3);
        run_streams(0);                         // Leaves results in the buffers
        checks++;
        if (retired_cnt == sent_cnt) begin
            $display("No result was pending when the flush was issued");
            errors++;
        end
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i  <= 1'b0;
        sent_cnt  = 0;
        next_tag  = '0;                         // Dispatch restarts at tag 0
        repeat (10) @(posedge clk_i);
        queue_tags(20, 2);
        run_streams(30);
        wait_drain();
        end_test("6 flush and restart", e0);

        $display("Checks: %0d, errors: %0d, retired: %0d", checks, errors, total_retired);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Backstop for a stuck run
    initial begin
        #200us;
        $display("Watchdog expired before the tests completed");
        $display("Simulation failed");
        $finish;
    end

endmodule : commit_tb

`default_nettype wire

// ==== files.f ====
hw/core_types_pkg.sv
hw/commit_cfg_pkg.sv
hw/commit_buffer.sv
hw/commit_arbiter.sv
hw/commit_stage.sv
hw/reorder_buffer.sv
hw/commit_top.sv
tests/commit_props.sv
tests/commit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the commit stage testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module commit_tb -f files.f -Mdir obj_dir

./obj_dir/Vcommit_tb | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi
echo "Result: PASS"
